/* all.f */
lsu_pkg.sv
lsu_align.sv
lsu_ctrl.sv
data_sram.sv
lsu_top.sv
lsu_checker.sv
tb_lsu.sv

/* data_sram.sv */
module data_sram
    import lsu_pkg::*;
#(
    parameter int LATENCY = MEM_LATENCY   // at least 1
) (
    input  logic        clk,
    input  logic        rst,
    // read address / read data
    input  logic        ar_valid,
    input  mem_rd_req_t ar,
    output logic        ar_ready,
    output logic        r_valid,
    output word_t       r_data,
    input  logic        r_ready,
    // write / write response
    input  logic        w_valid,
    input  mem_wr_req_t w,
    output logic        w_ready,
    output logic        b_valid,
    input  logic        b_ready
);

    typedef enum logic [1:0] {
        s_clear,   // zero sweep after reset
        s_idle,
        s_wait,    // counting latency
        s_resp
    } state_t;

    word_t    mem [MEM_WORDS];
    state_t   state;
    lat_cnt_t cnt;
    logic     is_rd;       // pending op is a read
    logic     rd_fire;
    logic     wr_fire;
    widx_t    rd_idx;
    widx_t    wr_idx;

    // index wraps modulo MEM_BYTES
    assign rd_idx = ar.addr[WIDX_W+1:2];
    assign wr_idx = w.addr[WIDX_W+1:2];

    assign ar_ready = (state == s_idle);
    assign w_ready  = (state == s_idle) && !ar_valid;   // read wins a tie
    assign rd_fire  = ar_valid && ar_ready;
    assign wr_fire  = w_valid && w_ready;

    assign r_valid = (state == s_resp) && is_rd;
    assign b_valid = (state == s_resp) && !is_rd;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_clear;
            cnt   <= '0;
            is_rd <= 1'b0;
        end else begin
            case (state)
                s_clear: state <= s_idle;
                s_idle: if (rd_fire || wr_fire) begin
                    is_rd <= rd_fire;
                    cnt   <= lat_cnt_t'(LATENCY - 1);
                    state <= s_wait;
                end
                s_wait: begin
                    if (cnt == '0)
                        state <= s_resp;
                    else
                        cnt <= cnt - 1'b1;
                end
                default: if (is_rd ? r_ready : b_ready) state <= s_idle;
            endcase
        end
    end

    // array and read data, no reset
    always_ff @(posedge clk) begin
        if (state == s_clear) begin
            for (int i = 0; i < MEM_WORDS; i++)
                mem[i] <= '0;
        end else if (wr_fire) begin
            for (int b = 0; b < 4; b++)
                if (w.strb[b])
                    mem[wr_idx][8*b +: 8] <= w.data[8*b +: 8];  // strobed bytes only
        end
        if (rd_fire)
            r_data <= mem[rd_idx];   // held until r_ready
    end

endmodule

/* lsu_align.sv */
module lsu_align
    import lsu_pkg::*;
(
    input  lsu_req_t    req,
    input  word_t       mem_word,     // raw word from memory
    output logic        misalign,
    output mem_wr_req_t wr_req,
    output word_t       load_data
);

    logic [1:0] off;       // byte offset within the word
    word_t      shifted;   // memory word moved down to lane 0

    assign off = req.addr[1:0];

    // halfwords need an even address, words a multiple of four
    always_comb begin
        case (req.op)
            op_lh, op_lhu, op_sh: misalign = off[0];
            op_lw, op_sw:         misalign = |off;
            default:              misalign = 1'b0;  // bytes are always aligned
        endcase
    end

    // store side
    always_comb begin
        wr_req.addr = {req.addr[31:2], 2'b00};  // also the read address
        case (req.op)
            op_sb: begin
                wr_req.data = {4{req.wdata[7:0]}};      // byte in every lane
                wr_req.strb = strb_t'(4'b0001 << off);
            end
            op_sh: begin
                wr_req.data = {2{req.wdata[15:0]}};     // half in both halves
                wr_req.strb = strb_t'(4'b0011 << off);
            end
            op_sw: begin
                wr_req.data = req.wdata;
                wr_req.strb = 4'b1111;
            end
            default: begin
                wr_req.data = req.wdata;
                wr_req.strb = 4'b0000;  // loads write nothing
            end
        endcase
    end

    // load side, shift by offset then extend
    assign shifted = mem_word >> {off, 3'b000};

    always_comb begin
        case (req.op)
            op_lb:   load_data = {{24{shifted[7]}}, shifted[7:0]};
            op_lbu:  load_data = {24'h0, shifted[7:0]};
            op_lh:   load_data = {{16{shifted[15]}}, shifted[15:0]};
            op_lhu:  load_data = {16'h0, shifted[15:0]};
            op_lw:   load_data = shifted;           // offset is zero here
            default: load_data = '0;                // stores return nothing
        endcase
    end

endmodule

/* lsu_checker.sv */
module lsu_checker
    import lsu_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        req_valid,
    input logic        req_ready,
    input logic        resp_valid,
    input logic        ar_valid,
    input mem_rd_req_t ar,
    input logic        ar_ready,
    input logic        r_ready,
    input logic        w_valid,
    input mem_wr_req_t w,
    input logic        w_ready,
    input logic        b_ready
);

    timeunit 1ns;
    timeprecision 1ps;

    // raised valid holds with a stable payload until ready
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar))
        else $error("ar_valid dropped or ar changed before the transfer");

    w_hold: assert property (@(posedge clk) disable iff (rst)
        w_valid && !w_ready |=> w_valid && $stable(w))
        else $error("w_valid dropped or w changed before the transfer");

    resp_pulse: assert property (@(posedge clk) disable iff (rst)
        resp_valid |=> !resp_valid)
        else $error("resp_valid high for two cycles");

    // no new request while one is in flight
    busy_after_accept: assert property (@(posedge clk) disable iff (rst)
        req_valid && req_ready |=> !req_ready)
        else $error("req_ready still high after acceptance");

    busy_on_channel: assert property (@(posedge clk) disable iff (rst)
        (ar_valid || w_valid || r_ready || b_ready) |-> !req_ready)
        else $error("req_ready high during a memory access");

    one_channel: assert property (@(posedge clk) disable iff (rst)
        !(ar_valid && w_valid))
        else $error("ar_valid and w_valid high together");

endmodule

bind lsu_ctrl lsu_checker u_checker (.*);

/* lsu_ctrl.sv */
module lsu_ctrl
    import lsu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // core side
    input  logic        req_valid,
    input  lsu_req_t    req,
    output logic        req_ready,
    output logic        resp_valid,
    output lsu_resp_t   resp,
    // read address / read data
    output logic        ar_valid,
    output mem_rd_req_t ar,
    input  logic        ar_ready,
    input  logic        r_valid,
    input  word_t       r_data,
    output logic        r_ready,
    // write / write response
    output logic        w_valid,
    output mem_wr_req_t w,
    input  logic        w_ready,
    input  logic        b_valid,
    output logic        b_ready
);

    typedef enum logic [2:0] {
        s_idle,
        s_rd_addr,
        s_rd_data,
        s_wr_req,
        s_wr_resp,
        s_done
    } state_t;

    state_t      state;
    lsu_req_t    req_q;      // request held for the whole access
    word_t       rdata_q;    // raw word from the read channel
    logic        err_q;
    lsu_req_t    al_req;     // what the align block looks at
    logic        al_misalign;
    mem_wr_req_t al_wr;
    word_t       al_load;
    logic        accept;

    assign accept = req_valid && req_ready;

    // live request while idle, latched one after that
    assign al_req = (state == s_idle) ? req : req_q;

    lsu_align u_align (
        .req       (al_req),
        .mem_word  (rdata_q),
        .misalign  (al_misalign),
        .wr_req    (al_wr),
        .load_data (al_load)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
            err_q <= 1'b0;
        end else begin
            case (state)
                s_idle: if (accept) begin
                    err_q <= al_misalign;
                    if (al_misalign)
                        state <= s_done;        // never reaches memory
                    else if (is_store(req.op))
                        state <= s_wr_req;
                    else
                        state <= s_rd_addr;
                end
                s_rd_addr: if (ar_ready) state <= s_rd_data;
                s_rd_data: if (r_valid)  state <= s_done;   // r_ready high here
                s_wr_req:  if (w_ready)  state <= s_wr_resp;
                s_wr_resp: if (b_valid)  state <= s_done;
                default:   state <= s_idle;                 // done lasts one cycle
            endcase
        end
    end

    // payload regs
    always_ff @(posedge clk) begin
        if (accept)
            req_q <= req;
        if (r_valid && r_ready)
            rdata_q <= r_data;
    end

    assign req_ready  = (state == s_idle);
    assign ar_valid   = (state == s_rd_addr);
    assign ar.addr    = al_wr.addr;                 // word address
    assign r_ready    = (state == s_rd_data);
    assign w_valid    = (state == s_wr_req);
    assign w          = al_wr;
    assign b_ready    = (state == s_wr_resp);

    assign resp_valid = (state == s_done);
    assign resp.err   = err_q;
    assign resp.rdata = (err_q || is_store(req_q.op)) ? '0 : al_load;

endmodule

/* lsu_pkg.sv */
package lsu_pkg;

    // memory geometry
    localparam int MEM_BYTES   = 1024;            // addresses wrap modulo this
    localparam int MEM_LATENCY = 2;               // default cycles, accept to response
    localparam int MEM_WORDS   = MEM_BYTES / 4;
    localparam int WIDX_W      = $clog2(MEM_WORDS);

    typedef logic [31:0]       word_t;            // data word
    typedef logic [31:0]       addr_t;            // byte address
    typedef logic [3:0]        strb_t;            // one bit per byte lane
    typedef logic [WIDX_W-1:0] widx_t;            // word index into the sram
    typedef logic [7:0]        lat_cnt_t;         // response delay counter

    // loads keep the read control codes of the old lsu, stores fill the rest
    typedef enum logic [2:0] {
        op_sw  = 3'b000,
        op_lb  = 3'b001,
        op_lbu = 3'b010,
        op_lh  = 3'b011,
        op_lhu = 3'b100,
        op_lw  = 3'b101,
        op_sb  = 3'b110,
        op_sh  = 3'b111
    } lsu_op_t;

    typedef struct packed {
        lsu_op_t op;
        addr_t   addr;
        word_t   wdata;   // store data, low bits used for sb/sh
    } lsu_req_t;

    typedef struct packed {
        word_t rdata;     // extended load value, zero for stores
        logic  err;       // misaligned access
    } lsu_resp_t;

    typedef struct packed {
        addr_t addr;      // word aligned
    } mem_rd_req_t;

    typedef struct packed {
        addr_t addr;      // word aligned
        word_t data;      // data already placed in its lanes
        strb_t strb;
    } mem_wr_req_t;

    function automatic logic is_store(lsu_op_t op);
        return (op == op_sb) || (op == op_sh) || (op == op_sw);
    endfunction

endpackage

/* lsu_top.sv */
module lsu_top
    import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid,
    input  lsu_req_t  req,
    output logic      req_ready,
    output logic      resp_valid,
    output lsu_resp_t resp
);

    // lsu to sram channels
    logic        ar_valid;
    mem_rd_req_t ar;
    logic        ar_ready;
    logic        r_valid;
    word_t       r_data;
    logic        r_ready;
    logic        w_valid;
    mem_wr_req_t w;
    logic        w_ready;
    logic        b_valid;
    logic        b_ready;

    lsu_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp       (resp),
        .ar_valid   (ar_valid),
        .ar         (ar),
        .ar_ready   (ar_ready),
        .r_valid    (r_valid),
        .r_data     (r_data),
        .r_ready    (r_ready),
        .w_valid    (w_valid),
        .w          (w),
        .w_ready    (w_ready),
        .b_valid    (b_valid),
        .b_ready    (b_ready)
    );

    data_sram #(
        .LATENCY (MEM_LATENCY)
    ) u_sram (
        .clk      (clk),
        .rst      (rst),
        .ar_valid (ar_valid),
        .ar       (ar),
        .ar_ready (ar_ready),
        .r_valid  (r_valid),
        .r_data   (r_data),
        .r_ready  (r_ready),
        .w_valid  (w_valid),
        .w        (w),
        .w_ready  (w_ready),
        .b_valid  (b_valid),
        .b_ready  (b_ready)
    );

endmodule

/* lsu_vectors.txt */
# columns: op addr wdata expected_rdata expected_err, all hex
# op codes: sw=0 lb=1 lbu=2 lh=3 lhu=4 lw=5 sb=6 sh=7
5 00000100 00000000 00000000 0
2 000003ff 00000000 00000000 0
0 00000010 12345678 00000000 0
5 00000010 00000000 12345678 0
7 00000012 00009abc 00000000 0
7 00000010 0000def0 00000000 0
5 00000010 00000000 9abcdef0 0
6 00000010 000000a5 00000000 0
6 00000011 000000b6 00000000 0
5 00000010 00000000 9abcb6a5 0
6 00000012 000000c7 00000000 0
6 00000013 000000d8 00000000 0
5 00000010 00000000 d8c7b6a5 0
1 00000010 00000000 ffffffa5 0
1 00000011 00000000 ffffffb6 0
1 00000012 00000000 ffffffc7 0
1 00000013 00000000 ffffffd8 0
2 00000010 00000000 000000a5 0
2 00000011 00000000 000000b6 0
2 00000012 00000000 000000c7 0
2 00000013 00000000 000000d8 0
3 00000010 00000000 ffffb6a5 0
3 00000012 00000000 ffffd8c7 0
4 00000010 00000000 0000b6a5 0
4 00000012 00000000 0000d8c7 0
3 00000011 00000000 00000000 1
4 00000013 00000000 00000000 1
5 00000012 00000000 00000000 1
0 00000012 deadbeef 00000000 1
7 00000011 00001234 00000000 1
5 00000010 00000000 d8c7b6a5 0
0 00000004 0badf00d 00000000 0
5 00000404 00000000 0badf00d 0
5 00000c04 00000000 0badf00d 0
0 00000408 13579bdf 00000000 0
5 00000008 00000000 13579bdf 0

/* run.sh */
#!/usr/bin/env bash
# build and run the lsu testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module tb_lsu -f all.f > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_lsu > sim.log 2>&1 || true
cat sim.log
! grep -q "Regression failed" sim.log && grep -q "Regression passed" sim.log \
    && echo "PASS" || { echo "FAIL"; exit 1; }

/* tb_lsu.sv */
module tb_lsu
    import lsu_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic      clk = 1'b0;
    logic      rst;
    logic      req_valid;
    lsu_req_t  req;
    logic      req_ready;
    logic      resp_valid;
    lsu_resp_t resp;

    // vector table, one entry per request
    lsu_op_t v_op[$];
    addr_t   v_addr[$];
    word_t   v_wdata[$];
    word_t   v_rdata[$];   // expected, zero for stores and errors
    logic    v_err[$];

    int errors = 0;
    int n_vec  = 0;

    lsu_top u_lsu_top (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    always #5 clk = ~clk;   // 10 ns period

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            errors++;
            $display("FAIL time %0t signal %s expected %h actual %h",
                     $time, name, expected, actual);
            $display("Regression failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic load_vectors();
        int         fd;
        int         n;
        string      line;
        logic [2:0] op;
        addr_t      addr;
        word_t      wd;
        word_t      rd;
        logic       er;
        fd = $fopen("lsu_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open lsu_vectors.txt");
            $display("Regression failed");
            $fatal(1, "vector file missing");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%h %h %h %h %h", op, addr, wd, rd, er);
            if (n == 5) begin   // header and blank lines scan short
                v_op.push_back(lsu_op_t'(op));
                v_addr.push_back(addr);
                v_wdata.push_back(wd);
                v_rdata.push_back(rd);
                v_err.push_back(er);
            end
        end
        $fclose(fd);
        if (v_op.size() == 0) begin
            $display("vector file holds no requests");
            $display("Regression failed");
            $fatal(1, "empty vector file");
        end
    endtask

    // one request, held until accepted, then wait for the completion pulse
    task automatic run_vector(input int i);
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= '{op: v_op[i], addr: v_addr[i], wdata: v_wdata[i]};
        @(negedge clk);                          // outputs settled mid-cycle
        while (!req_ready)
            @(negedge clk);
        @(posedge clk);                          // accepting edge
        req_valid <= 1'b0;
        @(negedge clk);
        while (!resp_valid)
            @(negedge clk);
        check_value($sformatf("resp.err (vector %0d)", i),
                    word_t'(v_err[i]), word_t'(resp.err));
        check_value($sformatf("resp.rdata (vector %0d)", i), v_rdata[i], resp.rdata);
    endtask

    initial begin
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        load_vectors();
        n_vec = v_op.size();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < n_vec; i++)
            run_vector(i);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    // watchdog, 20 cycles per request plus reset
    initial begin
        wait (n_vec > 0);
        repeat (n_vec * 20 + 10) @(posedge clk);
        $display("run timed out after %0d cycles", n_vec * 20 + 10);
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

endmodule
